//--- tb/wb_trace.txt
# kind S or X: addr data, R or L: addr expected, W: idle cycles (decimal), F or E: flag value
# S store, X store that overflows, L read with idle latency check, F wb_full, E wb_empty; hex
# state after reset
F 0
E 1
# store then read
S 10 0000a5a5
S 34 55aa0034
W 8
R 10 0000a5a5
L 10 0000a5a5
L 34 55aa0034
# merging into two entries
S 20 11111111
S 21 22222222
S 20 33333333
S 21 44444444
F 0
W 10
E 1
R 20 33333333
R 21 44444444
# fill to full, then one dropped store
S 30 a0000001
S 31 a0000002
S 32 a0000003
S 33 a0000004
X 34 deadbeef
F 1
W 20
E 1
R 31 a0000002
R 33 a0000004
R 34 55aa0034
# read right after a store to the same line
S 40 12345678
R 40 12345678
S 41 0badf00d
R 40 12345678
R 41 0badf00d
# other line read while the buffer drains
S 50 c0c0c0c0
R 10 0000a5a5
W 8
E 1
L 50 c0c0c0c0

//--- sim.f
common/wb_pkg.sv
write_buffer/write_buffer.sv
verilog/backing_mem.sv
verilog/mem_port_ctrl.sv
verilog/wb_subsystem.sv
tb/wb_sva.sv
tb/wb_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module wb_tb -o wb_sim
	-./obj_dir/wb_sim > sim.log 2>&1
	cat sim.log
	@if grep -q "Done: errors found" sim.log; then exit 1; fi
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/wb_tb.sv
// Trace-driven testbench with clock, reset, reference memory model, checks and run timeout

module wb_tb;
	import wb_pkg::*;

	localparam int DATA_LENGTH = wb_pkg::DATA_LENGTH_D;
	localparam int TAG_LENGTH = wb_pkg::TAG_LENGTH_D;
	localparam int WB_DEPTH = wb_pkg::WB_DEPTH_D;
	localparam int WORD_INDEX = wb_pkg::WORD_INDEX_D;
	localparam int HALF = 50;
	localparam int RESET_CYCLES = 16;
	// Read cycle, then data cycle
	localparam int IDLE_LATENCY = 2;

	logic cache_clk;
	logic rst_n;
	logic st_en;
	logic [TAG_LENGTH-1:0] st_addr;
	logic [DATA_LENGTH-1:0] st_data;
	logic rd_req;
	logic [TAG_LENGTH-1:0] rd_addr;
	logic rd_valid;
	logic [DATA_LENGTH-1:0] rd_data;
	logic wb_full;
	logic wb_empty;
	logic wb_overflow;

	// Memory as the cache sees it, dropped stores left out
	logic [DATA_LENGTH-1:0] ref_mem [1 << TAG_LENGTH];

	int value_errors;
	int other_errors;
	int cycle_count;
	int cycle_limit = 200;
	int fd;
	int trace_lines;
	int code;
	int wait_count;
	logic done;
	logic [7:0] kind;
	logic [31:0] arg_a;
	logic [31:0] arg_b;
	logic [8*256-1:0] line;

	wb_subsystem #(
		.DATA_LENGTH(DATA_LENGTH),
		.TAG_LENGTH(TAG_LENGTH),
		.WB_DEPTH(WB_DEPTH),
		.WORD_INDEX(WORD_INDEX)
	) u_dut (
		.cache_clk(cache_clk),
		.rst_n(rst_n),
		.st_en(st_en),
		.st_addr(st_addr),
		.st_data(st_data),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.wb_full(wb_full),
		.wb_empty(wb_empty),
		.wb_overflow(wb_overflow)
	);

	initial
	begin
		cache_clk = 1'b0;
		forever
			#HALF cache_clk = ~cache_clk;
	end

	////////////////////////////////////////
	// Run length guard
	////////////////////////////////////////

	initial
	begin
		cycle_count = 0;
		while (cycle_count < cycle_limit)
		begin
			@(posedge cache_clk);
			cycle_count++;
		end
		other_errors++;
		$display("Timeout: the trace did not finish within %0d cycles", cycle_limit);
		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		$display("Done: errors found");
		$finish;
	end

	task automatic clear_inputs();
		st_en = 1'b0;
		rd_req = 1'b0;
	endtask

	// One store cycle, overflow sampled mid low phase
	task automatic apply_store(input logic [TAG_LENGTH-1:0] addr,
		input logic [DATA_LENGTH-1:0] data, input logic expect_drop);
		@(negedge cache_clk);
		clear_inputs();
		st_en = 1'b1;
		st_addr = addr;
		st_data = data;
		#(HALF / 2);
		assert (wb_overflow === expect_drop)
		else
		begin
			$display("FAILED wb_overflow: got %h expected %h", wb_overflow, expect_drop);
			value_errors++;
		end
		if (!expect_drop)
			ref_mem[addr] = data;
	endtask

	// Hold the request until rd_valid, counting cycles
	task automatic run_read(input logic [TAG_LENGTH-1:0] addr,
		input logic [DATA_LENGTH-1:0] expected, input logic check_latency);
		int waited;
		waited = 0;
		assert (ref_mem[addr] === expected)
		else
		begin
			$display("FAILED trace_expected at %h: trace %h model %h",
				addr, expected, ref_mem[addr]);
			value_errors++;
		end
		@(negedge cache_clk);
		clear_inputs();
		rd_req = 1'b1;
		rd_addr = addr;
		do
		begin
			@(negedge cache_clk);
			waited++;
		end
		while (!rd_valid);
		rd_req = 1'b0;
		assert (rd_data === expected)
		else
		begin
			$display("FAILED rd_data at %h: got %h expected %h", addr, rd_data, expected);
			value_errors++;
		end
		if (check_latency)
		begin
			assert (waited == IDLE_LATENCY)
			else
			begin
				$display("FAILED rd_valid latency: got %h expected %h", waited, IDLE_LATENCY);
				value_errors++;
			end
		end
	endtask

	task automatic idle_cycles(input int count);
		repeat (count)
		begin
			@(negedge cache_clk);
			clear_inputs();
		end
	endtask

	task automatic check_flag(input logic [7:0] which, input logic expected);
		@(negedge cache_clk);
		clear_inputs();
		#(HALF / 2);
		if (which == "F")
		begin
			assert (wb_full === expected)
			else
			begin
				$display("FAILED wb_full: got %h expected %h", wb_full, expected);
				value_errors++;
			end
		end
		else
		begin
			assert (wb_empty === expected)
			else
			begin
				$display("FAILED wb_empty: got %h expected %h", wb_empty, expected);
				value_errors++;
			end
		end
	endtask

	////////////////////////////////////////
	// Trace playback
	////////////////////////////////////////

	initial
	begin
		rst_n = 1'b0;
		st_en = 1'b0;
		st_addr = '0;
		st_data = '0;
		rd_req = 1'b0;
		rd_addr = '0;
		value_errors = 0;
		other_errors = 0;
		trace_lines = 0;
		done = 1'b0;

		// Size the run limit from the trace length
		fd = $fopen("tb/wb_trace.txt", "r");
		if (fd != 0)
		begin
			while ($fgets(line, fd) != 0)
				trace_lines++;
			$fclose(fd);
		end
		cycle_limit = 20 * trace_lines + 200;

		fd = $fopen("tb/wb_trace.txt", "r");
		assert (fd != 0)
		else
		begin
			$display("The trace file tb/wb_trace.txt could not be opened");
			other_errors++;
			done = 1'b1;
		end

		repeat (RESET_CYCLES) @(negedge cache_clk);
		rst_n = 1'b1;

		while (!done)
		begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1)
				done = 1'b1;
			else if (kind == "#")
				code = $fgets(line, fd);
			else if (kind == "S" || kind == "X")
			begin
				code = $fscanf(fd, "%h %h", arg_a, arg_b);
				apply_store(arg_a[TAG_LENGTH-1:0], arg_b, kind == "X");
			end
			else if (kind == "R" || kind == "L")
			begin
				code = $fscanf(fd, "%h %h", arg_a, arg_b);
				run_read(arg_a[TAG_LENGTH-1:0], arg_b, kind == "L");
			end
			else if (kind == "W")
			begin
				code = $fscanf(fd, "%d", wait_count);
				idle_cycles(wait_count);
			end
			else if (kind == "F" || kind == "E")
			begin
				code = $fscanf(fd, "%h", arg_a);
				check_flag(kind, arg_a[0]);
			end
			else
			begin
				$display("The trace holds an unknown operation %c", kind);
				other_errors++;
				code = $fgets(line, fd);
			end
		end
		idle_cycles(1);

		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- tb/wb_sva.sv
// Concurrent assertions on buffer flags and memory port controller outputs, with their bind

module wb_sva
(
	input logic cache_clk,
	input logic rst_n,
	input logic store,
	input logic load,
	input logic wb_full,
	input logic wb_empty,
	input logic wb_read_tag_hit,
	input logic mem_we,
	input logic mem_re,
	input wb_pkg::ctrl_state_t state
);
	import wb_pkg::*;

	////////////////////////////////////////
	// Buffer flags
	////////////////////////////////////////

	a_flags_exclusive: assert property (@(posedge cache_clk) disable iff (!rst_n)
		!(wb_full && wb_empty))
		else $error("wb_full and wb_empty are high together");

	// Pop only from a non-empty buffer and never beside a store
	a_load_legal: assert property (@(posedge cache_clk) disable iff (!rst_n)
		load |-> (!wb_empty && !store))
		else $error("load raised while empty or during a store");

	////////////////////////////////////////
	// Memory port
	////////////////////////////////////////

	a_port_exclusive: assert property (@(posedge cache_clk) disable iff (!rst_n)
		!(mem_we && mem_re))
		else $error("mem_we and mem_re are high together");

	a_pop_then_write: assert property (@(posedge cache_clk) disable iff (!rst_n)
		load |=> mem_we)
		else $error("popped word was not written in the next cycle");

	// Memory read only once the line has left the buffer
	a_read_after_drain: assert property (@(posedge cache_clk) disable iff (!rst_n)
		(state == CTRL_READ) |-> !wb_read_tag_hit)
		else $error("memory read issued while its line is still in the buffer");

endmodule

bind mem_port_ctrl wb_sva u_wb_sva
(
	.cache_clk(cache_clk),
	.rst_n(rst_n),
	.store(store),
	.load(load),
	.wb_full(wb_full),
	.wb_empty(wb_empty),
	.wb_read_tag_hit(wb_read_tag_hit),
	.mem_we(mem_we),
	.mem_re(mem_re),
	.state(state)
);

//--- verilog/wb_subsystem.sv
// Top level joining the write buffer, memory port controller and backing memory

module wb_subsystem
#(
	parameter int DATA_LENGTH = wb_pkg::DATA_LENGTH_D,
	parameter int TAG_LENGTH = wb_pkg::TAG_LENGTH_D,
	parameter int WB_DEPTH = wb_pkg::WB_DEPTH_D,
	parameter int WORD_INDEX = wb_pkg::WORD_INDEX_D
)
(
	input logic cache_clk,
	input logic rst_n,
	input logic st_en,
	input logic [TAG_LENGTH-1:0] st_addr,
	input logic [DATA_LENGTH-1:0] st_data,
	input logic rd_req,
	input logic [TAG_LENGTH-1:0] rd_addr,
	output logic rd_valid,
	output logic [DATA_LENGTH-1:0] rd_data,
	output logic wb_full,
	output logic wb_empty,
	output logic wb_overflow
);
	import wb_pkg::*;

	// Buffer to controller
	logic [TAG_LENGTH+DATA_LENGTH-1:0] wb_head;
	logic wb_read_tag_hit;
	logic load;
	logic [TAG_LENGTH-WORD_INDEX-1:0] read_tag_in;

	// Controller to memory
	logic mem_we;
	logic mem_re;
	logic [TAG_LENGTH-1:0] mem_addr;
	logic [DATA_LENGTH-1:0] mem_wdata;
	logic [DATA_LENGTH-1:0] mem_rdata;

	write_buffer #(
		.DATA_LENGTH(DATA_LENGTH),
		.TAG_LENGTH(TAG_LENGTH),
		.WB_DEPTH(WB_DEPTH),
		.WORD_INDEX(WORD_INDEX)
	) u_write_buffer (
		.cache_clk(cache_clk),
		.rst_n(rst_n),
		.store(st_en),
		.load(load),
		.tag_in(st_addr),
		.data_in(st_data),
		.read_tag_in(read_tag_in),
		.data_out(wb_head),
		.full_flag(wb_full),
		.empty_flag(wb_empty),
		.overflow_flag(wb_overflow),
		.wb_read_tag_hit(wb_read_tag_hit)
	);

	mem_port_ctrl #(
		.DATA_LENGTH(DATA_LENGTH),
		.TAG_LENGTH(TAG_LENGTH),
		.WORD_INDEX(WORD_INDEX)
	) u_mem_port_ctrl (
		.cache_clk(cache_clk),
		.rst_n(rst_n),
		.store(st_en),
		.wb_empty(wb_empty),
		.wb_full(wb_full),
		.wb_read_tag_hit(wb_read_tag_hit),
		.wb_head(wb_head),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.mem_rdata(mem_rdata),
		.load(load),
		.read_tag_in(read_tag_in),
		.mem_we(mem_we),
		.mem_re(mem_re),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

	backing_mem #(
		.DATA_LENGTH(DATA_LENGTH),
		.TAG_LENGTH(TAG_LENGTH)
	) u_backing_mem (
		.cache_clk(cache_clk),
		.we(mem_we),
		.re(mem_re),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

endmodule

//--- verilog/mem_port_ctrl.sv
// Memory port controller FSM arbitrating write buffer drain against cache read misses

module mem_port_ctrl
#(
	parameter int DATA_LENGTH = wb_pkg::DATA_LENGTH_D,
	parameter int TAG_LENGTH = wb_pkg::TAG_LENGTH_D,
	parameter int WORD_INDEX = wb_pkg::WORD_INDEX_D
)
(
	input logic cache_clk,
	input logic rst_n,
	input logic store,
	input logic wb_empty,
	input logic wb_full,
	input logic wb_read_tag_hit,
	input logic [TAG_LENGTH+DATA_LENGTH-1:0] wb_head,
	input logic rd_req,
	input logic [TAG_LENGTH-1:0] rd_addr,
	input logic [DATA_LENGTH-1:0] mem_rdata,
	output logic load,
	output logic [TAG_LENGTH-WORD_INDEX-1:0] read_tag_in,
	output logic mem_we,
	output logic mem_re,
	output logic [TAG_LENGTH-1:0] mem_addr,
	output logic [DATA_LENGTH-1:0] mem_wdata,
	output logic rd_valid,
	output logic [DATA_LENGTH-1:0] rd_data
);
	import wb_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic [TAG_LENGTH-1:0] head_tag;
	logic [DATA_LENGTH-1:0] head_data;
	logic drain_ok;
	logic read_ok;

	assign {head_tag, head_data} = wb_head;

	// Line of the pending read, looked up in the buffer
	assign read_tag_in = rd_addr[TAG_LENGTH-1:WORD_INDEX];

	// Never pop while a store may merge into the head
	assign drain_ok = !wb_empty && !store;

	// A same-cycle store could still hit the read's line, so it waits too.
	// rd_valid high means the request on rd_req has just been answered.
	assign read_ok = rd_req && !rd_valid && !store && !wb_read_tag_hit;

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			CTRL_IDLE:
			begin
				// Read first, unless the buffer is full
				if (read_ok && !wb_full)
					state_nxt = CTRL_READ;
				else if (!wb_empty)
					state_nxt = CTRL_POP;
			end
			CTRL_POP:
			begin
				if (drain_ok)
					state_nxt = CTRL_WRITE;
			end
			CTRL_WRITE:
				state_nxt = CTRL_IDLE;
			CTRL_READ:
				state_nxt = CTRL_IDLE;
			default:
				state_nxt = CTRL_IDLE;
		endcase
	end

	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= CTRL_IDLE;
			rd_valid <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			// data cycle follows the read cycle
			rd_valid <= (state == CTRL_READ);
		end
	end

	////////////////////////////////////////
	// Memory and buffer side outputs
	////////////////////////////////////////

	assign load = (state == CTRL_POP) && drain_ok;
	assign mem_we = (state == CTRL_WRITE);
	assign mem_re = (state == CTRL_READ);
	assign mem_addr = (state == CTRL_WRITE) ? head_tag : rd_addr;
	assign mem_wdata = head_data;

	// Registered memory output is valid in the rd_valid cycle
	assign rd_data = mem_rdata;

endmodule

//--- verilog/backing_mem.sv
// Word-addressed backing memory with synchronous write and one-cycle registered read

module backing_mem
#(
	parameter int DATA_LENGTH = wb_pkg::DATA_LENGTH_D,
	parameter int TAG_LENGTH = wb_pkg::TAG_LENGTH_D
)
(
	input logic cache_clk,
	input logic we,
	input logic re,
	input logic [TAG_LENGTH-1:0] addr,
	input logic [DATA_LENGTH-1:0] wdata,
	output logic [DATA_LENGTH-1:0] rdata
);
	import wb_pkg::*;

	// One word per address, whole tag space covered
	localparam int DEPTH = 1 << TAG_LENGTH;

	logic [DATA_LENGTH-1:0] mem [DEPTH];

	////////////////////////////////////////
	// Single port access
	////////////////////////////////////////

	// Write port
	always_ff @(posedge cache_clk)
	begin
		if (we)
			mem[addr] <= wdata;
	end

	// Read data held until the next read
	always_ff @(posedge cache_clk)
	begin
		if (re)
			rdata <= mem[addr];
	end

endmodule

//--- write_buffer/write_buffer.sv
// Merging circular write buffer with store tag hit, line tag lookup and status flags

module write_buffer
#(
	parameter int DATA_LENGTH = wb_pkg::DATA_LENGTH_D,
	parameter int TAG_LENGTH = wb_pkg::TAG_LENGTH_D,
	parameter int WB_DEPTH = wb_pkg::WB_DEPTH_D,
	parameter int WORD_INDEX = wb_pkg::WORD_INDEX_D
)
(
	input logic cache_clk,
	input logic rst_n,
	input logic store,
	input logic load,
	input logic [TAG_LENGTH-1:0] tag_in,
	input logic [DATA_LENGTH-1:0] data_in,
	input logic [TAG_LENGTH-WORD_INDEX-1:0] read_tag_in,
	output logic [TAG_LENGTH+DATA_LENGTH-1:0] data_out,
	output logic full_flag,
	output logic empty_flag,
	output logic overflow_flag,
	output logic wb_read_tag_hit
);
	import wb_pkg::*;

	// Slot index width, kept at one bit for a single-entry buffer
	localparam int PTR_W = (WB_DEPTH > 1) ? $clog2(WB_DEPTH) : 1;
	localparam int LAST_SLOT = WB_DEPTH - 1;

	logic [TAG_LENGTH-1:0] tag_q [WB_DEPTH];
	logic [DATA_LENGTH-1:0] data_q [WB_DEPTH];
	logic [WB_DEPTH-1:0] valid;

	// Top bit of each pointer is the wrap bit
	logic [PTR_W:0] w_ptr;
	logic [PTR_W:0] r_ptr;
	logic [PTR_W-1:0] w_idx;
	logic [PTR_W-1:0] r_idx;
	logic [PTR_W-1:0] hit_idx;
	logic [PTR_W-1:0] wr_slot;
	logic hit;
	logic write_en;
	logic read_en;

	// Step a pointer, wrapping the index at WB_DEPTH and toggling the wrap bit
	function automatic logic [PTR_W:0] ptr_next(input logic [PTR_W:0] p);
		logic [PTR_W:0] n;
		if (p[PTR_W-1:0] == PTR_W'(LAST_SLOT))
			n = {~p[PTR_W], {PTR_W{1'b0}}};
		else
			n = p + 1'b1;
		return n;
	endfunction

	assign w_idx = w_ptr[PTR_W-1:0];
	assign r_idx = r_ptr[PTR_W-1:0];

	assign write_en = store && !full_flag;
	assign read_en = load && !empty_flag;

	// A merge overwrites the matching slot, a new tag takes the tail
	assign wr_slot = hit ? hit_idx : w_idx;

	////////////////////////////////////////
	// Pointers and valid bits
	////////////////////////////////////////

	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			w_ptr <= '0;
			r_ptr <= '0;
			valid <= '0;
		end
		else
		begin
			// tail only moves for a store with no match
			if (write_en && !hit)
				w_ptr <= ptr_next(w_ptr);
			if (read_en)
				r_ptr <= ptr_next(r_ptr);
			if (write_en)
				valid[wr_slot] <= 1'b1;
			if (read_en)
				valid[r_idx] <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Entry storage and head register
	////////////////////////////////////////

	always_ff @(posedge cache_clk)
	begin
		if (write_en)
		begin
			tag_q[wr_slot] <= tag_in;
			data_q[wr_slot] <= data_in;
		end
		// Head is sampled every edge, so a pop leaves it here
		data_out <= {tag_q[r_idx], data_q[r_idx]};
	end

	// Status flags
	assign full_flag = (w_idx == r_idx) && (w_ptr[PTR_W] != r_ptr[PTR_W]);
	assign empty_flag = (w_ptr == r_ptr);
	assign overflow_flag = full_flag && store;

	////////////////////////////////////////
	// Tag compares
	////////////////////////////////////////

	// Store tag against every valid entry
	always_comb
	begin
		hit = 1'b0;
		hit_idx = '0;
		for (int i = 0; i < WB_DEPTH; i++)
		begin
			if (valid[i] && (tag_q[i] == tag_in))
			begin
				hit = 1'b1;
				hit_idx = PTR_W'(i);
			end
		end
	end

	// Line part only, any pending word of the line counts
	always_comb
	begin
		wb_read_tag_hit = 1'b0;
		for (int i = 0; i < WB_DEPTH; i++)
		begin
			if (valid[i] && (tag_q[i][TAG_LENGTH-1:WORD_INDEX] == read_tag_in))
				wb_read_tag_hit = 1'b1;
		end
	end

endmodule

//--- common/wb_pkg.sv
// Package with default widths, buffer depth and the memory port controller state type

package wb_pkg;

	////////////////////////////////////////
	// Default widths and depths
	////////////////////////////////////////

	// Width of one data word
	parameter int DATA_LENGTH_D = 32;

	// Word address width, small enough that memory covers it all
	parameter int TAG_LENGTH_D = 8;

	// Low address bits that pick a word in a line (four-word lines)
	parameter int WORD_INDEX_D = 2;

	// Write buffer entries, any value from 1 up
	parameter int WB_DEPTH_D = 4;

	////////////////////////////////////////
	// Memory port controller states
	////////////////////////////////////////

	// idle  : choose between a cache read and a drain
	// pop   : pull the head entry once no store is present
	// write : popped word goes to memory
	// read  : memory read issued, data follows next cycle
	typedef enum logic [1:0]
	{
		CTRL_IDLE  = 2'd0,
		CTRL_POP   = 2'd1,
		CTRL_WRITE = 2'd2,
		CTRL_READ  = 2'd3
	} ctrl_state_t;

endpackage
